// ==== Makefile ====
# Verilator simulation of the clock-configuration panel.

VERILATOR ?= verilator
TOP       ?= tb_pll_ctrl
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/div_stage.sv ====
`timescale 1ns/1ps

module div_stage (
  input  logic clkp,
  input  logic rstxp,
  input  logic din,
  output logic dout
);

  logic din_d;

  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      din_d <= 1'b0;
    end else begin
      din_d <= din;
    end
  end

  // Output toggles once per rising edge of din.
  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      dout <= 1'b0;
    end else if (din & ~din_d) begin
      dout <= ~dout;
    end
  end

endmodule

// ==== rtl/panel_input.sv ====
`timescale 1ns/1ps

module panel_input import panel_pkg::*; (
  input  logic      clkp,
  input  logic      rstxp,
  input  logic      btn_up,
  input  logic      btn_dn,
  input  logic      req_ready,
  output logic      req_valid,
  output setting_t  req_setting,
  output seg_pair_t digits
);

  logic [2:0]   up_sync;
  logic [2:0]   dn_sync;
  logic         fall_up;
  logic         fall_dn;
  setting_t     index;
  setting_t     index_next;
  setting_req_t req;
  setting_t     ones_val;

  function automatic logic [6:0] seg7(input logic [3:0] d);
    case (d)
      4'd0:    seg7 = 7'b0111111;
      4'd1:    seg7 = 7'b0000110;
      4'd2:    seg7 = 7'b1011011;
      4'd3:    seg7 = 7'b1001111;
      4'd4:    seg7 = 7'b1100110;
      4'd5:    seg7 = 7'b1101101;
      4'd6:    seg7 = 7'b1111101;
      4'd7:    seg7 = 7'b0000111;
      4'd8:    seg7 = 7'b1111111;
      4'd9:    seg7 = 7'b1101111;
      default: seg7 = 7'b0000000;
    endcase
  endfunction

  // Two synchronizer flops, then the edge flop in bit 2.
  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      up_sync <= '0;
      dn_sync <= '0;
    end else begin
      up_sync <= {up_sync[1:0], btn_up};
      dn_sync <= {dn_sync[1:0], btn_dn};
    end
  end

  assign fall_up = up_sync[2] & ~up_sync[1];
  assign fall_dn = dn_sync[2] & ~dn_sync[1];

  // Down wins when both buttons fall together.
  assign index_next = fall_dn ? index - 1'b1 : index + 1'b1;

  always_comb begin
    req.valid   = (fall_up | fall_dn) & req_ready;
    req.setting = index_next;
  end

  assign req_valid   = req.valid;
  assign req_setting = req.setting;

  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      index <= '0;
    end else if (req.valid) begin
      index <= index_next;  // Presses without ready are dropped.
    end
  end

  assign ones_val = (index >= 4'd10) ? index - 4'd10 : index;

  always_comb begin
    digits.ones = seg7(ones_val);
    digits.tens = (index >= 4'd10) ? seg7(4'd1) : 7'b0000000;
  end

endmodule

// ==== rtl/panel_pkg.sv ====
`include "pll_ctrl_config.svh"

package panel_pkg;

  typedef logic [$clog2(`PLL_SETTINGS)-1:0] setting_t;

  // Segment bit 0 is segment a.
  typedef struct packed {
    logic [6:0] tens;
    logic [6:0] ones;
  } seg_pair_t;

  typedef struct packed {
    logic     valid;
    setting_t setting;
  } setting_req_t;

endpackage

// ==== rtl/pll_ctrl.sv ====
`timescale 1ns/1ps
`include "pll_ctrl_config.svh"

module pll_ctrl import pll_drp_pkg::*, panel_pkg::*; (
  input  logic       clkp,
  input  logic       rstxp,
  input  logic       btn_up,
  input  logic       btn_dn,
  output logic [6:0] digit0,
  output logic [6:0] digit1,
  output logic       pll_lock,
  output logic       div32
);

  logic                 rst_d1;
  logic                 rst_n;
  logic                 lock_d1;
  logic                 div_rst_n;
  logic                 req_valid;
  logic                 req_ready;
  setting_t             req_setting;
  seg_pair_t            digits;
  drp_req_t             drp_req;
  drp_rsp_t             drp_rsp;
  logic                 pll_rst;
  logic                 locked;
  logic                 tick;
  logic [`DIV_STAGES:0] div_chain;

  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      {rst_n, rst_d1} <= 2'b00;
    end else begin
      {rst_n, rst_d1} <= {rst_d1, 1'b1};
    end
  end

  // Divider chain leaves reset two cycles after lock.
  always_ff @(posedge clkp or negedge rst_n) begin
    if (!rst_n) begin
      {div_rst_n, lock_d1} <= 2'b00;
    end else begin
      {div_rst_n, lock_d1} <= {lock_d1, locked};
    end
  end

  panel_input u_panel (
    .clkp        (clkp),
    .rstxp       (rst_n),
    .btn_up      (btn_up),
    .btn_dn      (btn_dn),
    .req_ready   (req_ready),
    .req_valid   (req_valid),
    .req_setting (req_setting),
    .digits      (digits)
  );

  pll_drp_seq u_seq (
    .clkp        (clkp),
    .rstxp       (rst_n),
    .req_valid   (req_valid),
    .req_setting (req_setting),
    .req_ready   (req_ready),
    .drp_req     (drp_req),
    .drp_rsp     (drp_rsp),
    .locked      (locked),
    .pll_rst     (pll_rst)
  );

  pll_model u_pll (
    .clkp    (clkp),
    .rstxp   (rst_n),
    .pll_rst (pll_rst),
    .drp_req (drp_req),
    .drp_rsp (drp_rsp),
    .locked  (locked),
    .tick    (tick)
  );

  assign div_chain[0] = tick;

  for (genvar i = 0; i < `DIV_STAGES; i++) begin : g_div
    div_stage u_div (
      .clkp  (clkp),
      .rstxp (div_rst_n),
      .din   (div_chain[i]),
      .dout  (div_chain[i+1])
    );
  end

  assign div32    = div_chain[`DIV_STAGES];
  assign pll_lock = locked;
  assign digit0   = digits.ones;
  assign digit1   = digits.tens;

endmodule

// ==== rtl/pll_ctrl_config.svh ====
`ifndef PLL_CTRL_CONFIG_SVH
`define PLL_CTRL_CONFIG_SVH

// Setting indexes selectable from the panel.
`define PLL_SETTINGS    16

// Cycles from synthesizer reset release to lock.
`define PLL_LOCK_CYCLES 24

// Divide-by-two stages between the synthesizer tick and div32.
`define DIV_STAGES      5

`define DRP_DIV_ADDR    5'h08
`define DIV_FIELD_W     6
`define DIV_RESET       16'h1000

// Divide value for index 0.
`define DIV_BASE        2

`endif

// ==== rtl/pll_drp_pkg.sv ====
package pll_drp_pkg;

  // Divide value as held in the synthesizer divide register.
  typedef logic [15:0] div_val_t;

  typedef struct packed {
    logic        den;   // One-cycle access strobe.
    logic        dwe;   // High for a write.
    logic [4:0]  daddr;
    logic [15:0] di;
  } drp_req_t;

  typedef struct packed {
    logic        drdy;  // Pulses two cycles after den.
    logic [15:0] dout;
  } drp_rsp_t;

endpackage

// ==== rtl/pll_drp_seq.sv ====
`timescale 1ns/1ps
`include "pll_ctrl_config.svh"

module pll_drp_seq import pll_drp_pkg::*, panel_pkg::*; (
  input  logic     clkp,
  input  logic     rstxp,
  input  logic     req_valid,
  input  setting_t req_setting,
  output logic     req_ready,
  output drp_req_t drp_req,
  input  drp_rsp_t drp_rsp,
  input  logic     locked,
  output logic     pll_rst
);

  typedef enum logic [2:0] {
    S_RST,
    S_RD,
    S_RD_WAIT,
    S_WR,
    S_WR_WAIT,
    S_REL,
    S_LOCK,
    S_IDLE
  } state_t;

  state_t      state;
  setting_t    target;
  logic [15:0] rd_data;
  div_val_t    div_val;

  assign div_val   = div_val_t'(target) + div_val_t'(`DIV_BASE);
  assign req_ready = (state == S_IDLE);
  assign pll_rst   = state inside {S_RST, S_RD, S_RD_WAIT, S_WR, S_WR_WAIT};

  // Upper bits of the divide register are written back as read.
  always_comb begin
    drp_req.den   = (state == S_RD) || (state == S_WR);
    drp_req.dwe   = (state == S_WR);
    drp_req.daddr = `DRP_DIV_ADDR;
    drp_req.di    = {rd_data[15:`DIV_FIELD_W], div_val[`DIV_FIELD_W-1:0]};
  end

  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      state  <= S_RST;   // First pass programs setting 0.
      target <= '0;
    end else begin
      case (state)
        S_RST:     state <= S_RD;
        S_RD:      state <= S_RD_WAIT;
        S_RD_WAIT: if (drp_rsp.drdy) state <= S_WR;
        S_WR:      state <= S_WR_WAIT;
        S_WR_WAIT: if (drp_rsp.drdy) state <= S_REL;
        S_REL:     state <= S_LOCK;
        S_LOCK:    if (locked) state <= S_IDLE;
        S_IDLE: begin
          if (req_valid) begin
            target <= req_setting;
            state  <= S_RST;
          end
        end
        default:   state <= S_RST;
      endcase
    end
  end

  always_ff @(posedge clkp) begin
    if (state == S_RD_WAIT && drp_rsp.drdy) begin
      rd_data <= drp_rsp.dout;
    end
  end

endmodule

// ==== rtl/pll_model.sv ====
`timescale 1ns/1ps
`include "pll_ctrl_config.svh"

module pll_model import pll_drp_pkg::*; (
  input  logic     clkp,
  input  logic     rstxp,
  input  logic     pll_rst,
  input  drp_req_t drp_req,
  output drp_rsp_t drp_rsp,
  output logic     locked,
  output logic     tick
);

  localparam int LOCK_W = $clog2(`PLL_LOCK_CYCLES);

  logic [15:0]       regs [32];
  div_val_t          div_reg;
  div_val_t          div_len;
  div_val_t          div_cnt;
  logic              acc_vld;
  logic [15:0]       acc_dout;
  logic              rsp_drdy;
  logic [15:0]       rsp_dout;
  logic [LOCK_W-1:0] lock_cnt;

  assign div_len = div_val_t'(div_reg[`DIV_FIELD_W-1:0]);
  assign drp_rsp = '{drdy: rsp_drdy, dout: rsp_dout};

  // Access is sampled on den and answered one stage later.
  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      acc_vld  <= 1'b0;
      rsp_drdy <= 1'b0;
      div_reg  <= `DIV_RESET | div_val_t'(`DIV_BASE);
    end else begin
      acc_vld  <= drp_req.den;
      rsp_drdy <= acc_vld;
      if (drp_req.den && drp_req.dwe && drp_req.daddr == `DRP_DIV_ADDR) begin
        div_reg <= drp_req.di;
      end
    end
  end

  always_ff @(posedge clkp) begin
    if (drp_req.den) begin
      acc_dout <= (drp_req.daddr == `DRP_DIV_ADDR) ? div_reg : regs[drp_req.daddr];
      if (drp_req.dwe) begin
        regs[drp_req.daddr] <= drp_req.di;
      end
    end
    rsp_dout <= acc_dout;
  end

  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp || pll_rst) begin
      lock_cnt <= '0;
      locked   <= 1'b0;
    end else if (!locked) begin
      if (lock_cnt == LOCK_W'(`PLL_LOCK_CYCLES - 1)) begin
        locked <= 1'b1;
      end else begin
        lock_cnt <= lock_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else if (!locked) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else if (div_cnt == div_len - 1'b1) begin
      div_cnt <= '0;
      tick    <= 1'b1;  // One pulse per divide period.
    end else begin
      div_cnt <= div_cnt + 1'b1;
      tick    <= 1'b0;
    end
  end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/pll_drp_pkg.sv
rtl/panel_pkg.sv
rtl/panel_input.sv
rtl/pll_drp_seq.sv
rtl/pll_model.sv
rtl/div_stage.sv
rtl/pll_ctrl.sv
verif/tb_clock.sv
verif/tb_pll_ctrl.sv

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clkp,
  output logic rstxp
);

  localparam int HALF_PERIOD = 2;  // 4 ns clock.
  localparam int RESET_CYCLES = 16;

  initial begin
    clkp  = 1'b0;
    rstxp = 1'b0;
    repeat (RESET_CYCLES) @(posedge clkp);
    #1;
    rstxp = 1'b1;  // Release just after an edge.
  end

  always #HALF_PERIOD clkp = ~clkp;

endmodule

// ==== verif/tb_pll_ctrl.sv ====
`timescale 1ns/1ps
`include "pll_ctrl_config.svh"

module tb_pll_ctrl import panel_pkg::*; ();

  // Worst-case cycles for one press with relock and for one three-rise period check.
  localparam int PRESS_CYC  = 64;
  localparam int PERIOD_CYC = 16 * 17 + 2 * 32 * 17 + 64;
  localparam int T_TOTAL    = 80 + 8 * PRESS_CYC + 6 * PRESS_CYC
                              + 3 * (4 * PRESS_CYC + PERIOD_CYC);
  localparam int MAX_CYCLES = 3 * T_TOTAL / 2;

  logic       clkp;
  logic       rstxp;
  logic       btn_up;
  logic       btn_dn;
  logic [6:0] digit0;
  logic [6:0] digit1;
  logic       pll_lock;
  logic       div32;
  logic       mark;        // Marks the drive cycle of a press that must be accepted.
  logic       mark_dir;
  logic [3:0] acc_q;
  setting_t   exp_idx;
  logic       div32_q;
  logic [15:0] rise_gap;
  logic       period_chk;
  int         errors;
  int         tests_done;
  int         err_mark;
  int         cycles;

  tb_clock u_clock (
    .clkp  (clkp),
    .rstxp (rstxp)
  );

  pll_ctrl dut (
    .clkp     (clkp),
    .rstxp    (rstxp),
    .btn_up   (btn_up),
    .btn_dn   (btn_dn),
    .digit0   (digit0),
    .digit1   (digit1),
    .pll_lock (pll_lock),
    .div32    (div32)
  );

  function automatic logic [6:0] glyph(input int d);
    case (d)
      0:       glyph = 7'h3f;
      1:       glyph = 7'h06;
      2:       glyph = 7'h5b;
      3:       glyph = 7'h4f;
      4:       glyph = 7'h66;
      5:       glyph = 7'h6d;
      6:       glyph = 7'h7d;
      7:       glyph = 7'h07;
      8:       glyph = 7'h7f;
      default: glyph = 7'h6f;
    endcase
  endfunction

  // Tens digit stays dark below ten.
  function automatic logic [13:0] expected_digits(input setting_t idx);
    int v;
    v = int'(idx);
    expected_digits = {(v >= 10) ? glyph(1) : 7'h00, glyph(v % 10)};
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("error %0t: %s", $time, msg);
  endtask

  // A marked press reaches the index model three edges after it is driven.
  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      acc_q    <= '0;
      exp_idx  <= '0;
      div32_q  <= 1'b0;
      rise_gap <= '0;
    end else begin
      acc_q   <= {acc_q[2:0], mark};
      div32_q <= div32;
      if (acc_q[1]) begin
        exp_idx <= mark_dir ? exp_idx + 4'd1 : exp_idx - 4'd1;
      end
      rise_gap <= (div32 && !div32_q) ? 16'd1 : rise_gap + 16'd1;
    end
  end

  a_reset: assert property (@(posedge clkp) $rose(rstxp) |-> !pll_lock && !div32)
    else flag_error("pll_lock or div32 high at reset release");

  a_digits: assert property (@(posedge clkp) disable iff (!rstxp)
    {digit1, digit0} == expected_digits(exp_idx))
    else flag_error("digits do not match the expected index");

  a_lock_fall: assert property (@(posedge clkp) disable iff (!rstxp) acc_q[3] |-> !pll_lock)
    else flag_error("pll_lock still high two cycles after an accepted press");

  a_period: assert property (@(posedge clkp) disable iff (!rstxp)
    period_chk && div32 && !div32_q |-> rise_gap == 16'(32 * (int'(exp_idx) + `DIV_BASE)))
    else flag_error("div32 period differs from 32 x divide value");

  task automatic press_button(input logic up, input logic accept);
    @(posedge clkp);
    #1;
    if (up) begin
      btn_up = 1'b0;
    end else begin
      btn_dn = 1'b0;
    end
    mark = accept;
    if (accept) begin
      mark_dir = up;
    end
    @(posedge clkp);
    #1;
    mark = 1'b0;
    repeat (3) @(posedge clkp);
    #1;
    btn_up = 1'b1;
    btn_dn = 1'b1;
  endtask

  // The sequencer is idle one cycle after lock rises.
  task automatic wait_lock;
    do begin
      @(posedge clkp);
      #1;
    end while (pll_lock !== 1'b1);
    repeat (2) @(posedge clkp);
  endtask

  task automatic accepted_press(input logic up);
    press_button(up, 1'b1);
    wait_lock();
  endtask

  task automatic await_div32_rise;
    logic prev;
    prev = 1'b1;
    while (!(div32 && !prev)) begin
      prev = div32;
      @(posedge clkp);
      #1;
    end
    @(posedge clkp);
    #1;
  endtask

  task automatic finish_test(input string name);
    tests_done++;
    $display("test %0d %s: %0d errors", tests_done, name, errors - err_mark);
    err_mark = errors;
  endtask

  always @(posedge clkp) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run exceeded %0d cycles", MAX_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    int  n;
    logic up_dir;
    btn_up     = 1'b1;
    btn_dn     = 1'b1;
    mark       = 1'b0;
    mark_dir   = 1'b1;
    period_chk = 1'b0;
    errors     = 0;
    tests_done = 0;
    err_mark   = 0;
    cycles     = 0;
    void'($urandom(32'ha8da_7826));

    wait (rstxp === 1'b1);
    wait_lock();
    finish_test("reset and initial lock");

    accepted_press(1'b0);  // 0 wraps down to 15.
    accepted_press(1'b1);
    for (int i = 0; i < 6; i++) begin
      accepted_press(($urandom() % 2) == 1);
    end
    finish_test("up and down presses with wrap");

    for (int i = 0; i < 3; i++) begin
      press_button(1'b1, 1'b1);
      press_button(1'b0, 1'b0);  // Lands while the synthesizer is relocking.
      wait_lock();
    end
    finish_test("lock drop, relock and press during relock ignored");

    for (int t = 0; t < 3; t++) begin
      n      = 1 + int'($urandom() % 4);
      up_dir = ($urandom() % 2) == 1;
      for (int i = 0; i < n; i++) begin
        accepted_press(up_dir);
      end
      await_div32_rise();
      period_chk = 1'b1;
      await_div32_rise();
      await_div32_rise();
      period_chk = 1'b0;
    end
    finish_test("div32 period");

    $display("tests %0d, errors %0d", tests_done, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
